// ==== bp_patterns.txt ====
// ctrl pc instr link upd_pc upd_target exp_flags exp_target, one cycle per line
// ctrl digits: stall flush redirect br_taken holdoff disable instr_valid update
// update digit: 1 valid not taken, 3 valid taken; exp_flags: used ras holdoff taken
00000003 00001000 00000013 00000000 00001010 00002000 0000 00000000
00000000 00001010 00000013 00000000 00000000 00000000 1001 00002000
00000000 00001010 00000013 00000000 00000000 00000000 0011 00000000
00000000 00001010 00000013 00000000 00000000 00000000 1001 00002000
01000000 00002010 00000013 00000000 00000000 00000000 0010 00000000
01000000 00001010 00000013 00000000 00000000 00000000 1001 00002000
00000000 00002010 00000013 00000000 00000000 00000000 0000 00000000
10000000 00001010 00000013 00000000 00000000 00000000 0001 00000000
00100000 00001010 00000013 00000000 00000000 00000000 0001 00000000
00001000 00001010 00000013 00000000 00000000 00000000 0001 00000000
00000100 00001010 00000013 00000000 00000000 00000000 0001 00000000
00010000 00001010 00000013 00000000 00000000 00000000 0001 00000000
00000010 00003000 000000ef 00003004 00000000 00000000 0000 00000000
00000010 00004000 000002ef 00004004 00000000 00000000 0000 00000000
00000010 00005000 00008067 00000000 00000000 00000000 1101 00004004
00000000 00006000 00000013 00000000 00000000 00000000 0010 00000000
00000010 00001010 00008067 00000000 00000000 00000000 1101 00003004
00000000 00006000 00000013 00000000 00000000 00000000 0010 00000000
00000011 00006000 00008067 00000000 00001010 00002000 0000 00000000
00000000 00001010 00000013 00000000 00000000 00000000 0000 00000000
00000000 00000000 00000013 00000000 00000000 00000000 0000 00000000

// ==== build.f ====
+incdir+.
bp_pkg.sv
btb.sv
ras_detector.sv
return_address_stack.sv
branch_prediction_controller.sv
bp_props.sv
tb_branch_prediction_controller.sv

// ==== Bender.yml ====
package:
  name: branch_prediction_controller

sources:
  - include_dirs:
      - .
    files:
      - bp_pkg.sv
      - btb.sv
      - ras_detector.sv
      - return_address_stack.sv
      - branch_prediction_controller.sv
  - target: test
    files:
      - bp_props.sv
      - tb_branch_prediction_controller.sv

// ==== tb_branch_prediction_controller.sv ====
// ========================================
// Testbench for the branch prediction controller
// Replays bp_patterns.txt one line per cycle,
// drives on the falling edge, checks mid-cycle
// ========================================

`timescale 1ns/100ps

module tb_branch_prediction_controller;

  import bp_pkg::*;

  localparam int num_patterns   = 21;
  localparam int words_per_line = 8;
  localparam int reset_limit    = 40;

  // DUT inputs
  logic        i_clk;
  logic        i_reset;
  addr_t       i_pc;
  logic        i_stall;
  logic        i_flush;
  logic        i_redirect;
  logic        i_branch_taken;
  logic        i_holdoff;
  logic        i_disable;
  btb_update_t i_btb_update;
  instr_u      i_instruction;
  logic        i_instruction_valid;
  addr_t       i_link_address;

  // DUT outputs
  logic        o_predicted_taken;
  addr_t       o_predicted_target;
  logic        o_prediction_used;
  prediction_t o_prediction_r;
  logic        o_prediction_holdoff;
  logic        o_btb_only_holdoff;
  logic        o_ras_predicted;

  // Pattern storage and bookkeeping
  logic [31:0] pat_mem [num_patterns*words_per_line];
  int          checks;
  int          errors;
  logic        line_ok;
  logic        prev_used;
  logic        prev_ras;
  addr_t       prev_target;

  branch_prediction_controller UUT (
    .i_clk                (i_clk),
    .i_reset              (i_reset),
    .i_pc                 (i_pc),
    .i_stall              (i_stall),
    .i_flush              (i_flush),
    .i_redirect           (i_redirect),
    .i_branch_taken       (i_branch_taken),
    .i_holdoff            (i_holdoff),
    .i_disable            (i_disable),
    .i_btb_update         (i_btb_update),
    .i_instruction        (i_instruction),
    .i_instruction_valid  (i_instruction_valid),
    .i_link_address       (i_link_address),
    .o_predicted_taken    (o_predicted_taken),
    .o_predicted_target   (o_predicted_target),
    .o_prediction_used    (o_prediction_used),
    .o_prediction_r       (o_prediction_r),
    .o_prediction_holdoff (o_prediction_holdoff),
    .o_btb_only_holdoff   (o_btb_only_holdoff),
    .o_ras_predicted      (o_ras_predicted)
  );

  // 100 ns clock
  always #50 i_clk = ~i_clk;

  // Reset high for 8 rising edges, released on a falling edge
  initial begin
    i_reset = 1'b1;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;
  end

  // ========================================
  // Typed compare tasks
  // ========================================
  task automatic compare_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
      line_ok = 1'b0;
    end
  endtask

  task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      line_ok = 1'b0;
    end
  endtask

  task automatic compare_prediction(input prediction_t got, input prediction_t exp,
                                    input string what);
    checks++;
    if (got !== exp) begin
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
      line_ok = 1'b0;
    end
  endtask

  // ========================================
  // Pattern line handling
  // ========================================
  // Control word holds one flag per hex digit, update digit is {taken, valid}
  task automatic apply_line(input int n);
    logic [31:0] ctrl;
    ctrl                = pat_mem[n*words_per_line];
    i_stall             = ctrl[28];
    i_flush             = ctrl[24];
    i_redirect          = ctrl[20];
    i_branch_taken      = ctrl[16];
    i_holdoff           = ctrl[12];
    i_disable           = ctrl[8];
    i_instruction_valid = ctrl[4];
    i_btb_update.valid  = ctrl[0];
    i_btb_update.taken  = ctrl[1];
    i_pc                = pat_mem[n*words_per_line+1];
    i_instruction       = pat_mem[n*words_per_line+2];
    i_link_address      = pat_mem[n*words_per_line+3];
    i_btb_update.pc     = pat_mem[n*words_per_line+4];
    i_btb_update.target = pat_mem[n*words_per_line+5];
  endtask

  // Expected digits are used, ras_predicted, holdoff, predicted_taken
  task automatic check_line(input int n);
    logic [31:0] exp_flags;
    addr_t       exp_target;
    prediction_t exp_pred;
    logic        exp_btb_only;
    exp_flags  = pat_mem[n*words_per_line+6];
    exp_target = pat_mem[n*words_per_line+7];
    compare_bit(o_prediction_used, exp_flags[12], "o_prediction_used");
    compare_bit(o_ras_predicted, exp_flags[8], "o_ras_predicted");
    compare_bit(o_prediction_holdoff, exp_flags[4], "o_prediction_holdoff");
    compare_bit(o_predicted_taken, exp_flags[0], "o_predicted_taken");
    // BTB-only holdoff follows a used prediction that did not come from the stack
    exp_btb_only = exp_flags[4] && !prev_ras;
    compare_bit(o_btb_only_holdoff, exp_btb_only, "o_btb_only_holdoff");
    // Target only means something when a prediction is used
    if (exp_flags[12]) begin
      compare_addr(o_predicted_target, exp_target, "o_predicted_target");
    end
    // Metadata is the prediction of the last unstalled cycle
    if (prev_used) begin
      exp_pred.used   = 1'b1;
      exp_pred.target = prev_target;
      compare_prediction(o_prediction_r, exp_pred, "o_prediction_r");
    end else begin
      compare_bit(o_prediction_r.used, 1'b0, "o_prediction_r.used");
    end
    if (!i_stall) begin
      prev_used   = exp_flags[12];
      prev_ras    = exp_flags[8];
      prev_target = exp_target;
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    int waited;
    i_clk               = 1'b0;
    i_pc                = '0;
    i_stall             = 1'b0;
    i_flush             = 1'b0;
    i_redirect          = 1'b0;
    i_branch_taken      = 1'b0;
    i_holdoff           = 1'b0;
    i_disable           = 1'b0;
    i_btb_update        = '0;
    i_instruction       = '0;
    i_instruction_valid = 1'b0;
    i_link_address      = '0;
    checks              = 0;
    errors              = 0;
    prev_used           = 1'b0;
    prev_ras            = 1'b0;
    prev_target         = '0;
    $readmemh("bp_patterns.txt", pat_mem);

    waited = 0;
    while (i_reset !== 1'b0 && waited < reset_limit) begin
      @(posedge i_clk);
      waited++;
    end

    if (i_reset !== 1'b0) begin
      $display("Timeout: reset was not released within %0d clock cycles", reset_limit);
      $display("Result: FAILED");
      $finish;
    end else begin
      if ($isunknown(pat_mem[num_patterns*words_per_line-1])) begin
        $display("The pattern file is missing or has too few lines");
        errors++;
      end else begin
        for (int n = 0; n < num_patterns; n++) begin
          @(negedge i_clk);
          line_ok = 1'b1;
          apply_line(n);
          // Combinational outputs settle well before the next rising edge
          #10;
          check_line(n);
          $display("Pattern %0d %s", n + 1, line_ok ? "ok" : "had errors");
        end
      end
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

endmodule : tb_branch_prediction_controller

// ==== bp_props.sv ====
// ========================================
// Holdoff and reset properties of the
// prediction controller, bound to its top
// ========================================

`timescale 1ns/100ps

module bp_props (
  input logic                i_clk,
  input logic                i_reset,
  input logic                i_stall,
  input logic                i_flush,
  input logic                o_prediction_used,
  input logic                o_ras_predicted,
  input logic                o_prediction_holdoff,
  input logic                o_btb_only_holdoff,
  input bp_pkg::prediction_t o_prediction_r
);

  // Used prediction blocks the following fetch
  assert property (@(posedge i_clk) disable iff (i_reset)
    (o_prediction_used && !i_stall && !i_flush) |=> o_prediction_holdoff)
    else $error("holdoff missing after a used prediction");

  // Nothing predicts while held off, and the metadata records no use
  assert property (@(posedge i_clk) disable iff (i_reset)
    (o_prediction_holdoff && !i_stall) |-> !o_prediction_used ##1 !o_prediction_r.used)
    else $error("prediction used during holdoff");

  // Combinational outputs low in reset, registers cleared one edge later
  assert property (@(posedge i_clk)
    i_reset |-> (!o_prediction_used && !o_ras_predicted) ##1
      (o_prediction_r == '0 && !o_prediction_holdoff && !o_btb_only_holdoff))
    else $error("outputs not low during reset");

endmodule : bp_props

bind branch_prediction_controller bp_props u_props (
  .i_clk                (i_clk),
  .i_reset              (i_reset),
  .i_stall              (i_stall),
  .i_flush              (i_flush),
  .o_prediction_used    (o_prediction_used),
  .o_ras_predicted      (o_ras_predicted),
  .o_prediction_holdoff (o_prediction_holdoff),
  .o_btb_only_holdoff   (o_btb_only_holdoff),
  .o_prediction_r       (o_prediction_r)
);

// ==== branch_prediction_controller.sv ====
// ========================================
// Fetch-stage branch prediction controller
// Combines BTB and RAS predictions, gates
// them and registers metadata and holdoffs
// ========================================

`timescale 1ns/100ps

module branch_prediction_controller (
  input  logic                i_clk,
  input  logic                i_reset,
  input  bp_pkg::addr_t       i_pc,
  input  logic                i_stall,
  input  logic                i_flush,
  input  logic                i_redirect,
  input  logic                i_branch_taken,
  input  logic                i_holdoff,
  input  logic                i_disable,
  input  bp_pkg::btb_update_t i_btb_update,
  input  bp_pkg::instr_u      i_instruction,
  input  logic                i_instruction_valid,
  input  bp_pkg::addr_t       i_link_address,
  output logic                o_predicted_taken,
  output bp_pkg::addr_t       o_predicted_target,
  output logic                o_prediction_used,
  output bp_pkg::prediction_t o_prediction_r,
  output logic                o_prediction_holdoff,
  output logic                o_btb_only_holdoff,
  output logic                o_ras_predicted
);

  import bp_pkg::*;

  // ========================================
  // Prediction sources
  // ========================================
  logic  btb_hit;
  logic  btb_taken;
  addr_t btb_target;

  btb u_btb (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_pc     (i_pc),
    .i_update (i_btb_update),
    .o_hit    (btb_hit),
    .o_taken  (btb_taken),
    .o_target (btb_target)
  );

  logic  ras_is_call;
  logic  ras_is_return;
  logic  ras_allowed;
  logic  ras_valid;
  addr_t ras_target;

  ras_detector u_ras_detector (
    .i_instruction       (i_instruction),
    .i_instruction_valid (i_instruction_valid),
    .o_is_call           (ras_is_call),
    .o_is_return         (ras_is_return)
  );

  return_address_stack u_ras (
    .i_clk                (i_clk),
    .i_reset              (i_reset),
    .i_stall              (i_stall),
    .i_is_call            (ras_is_call),
    .i_is_return          (ras_is_return),
    .i_prediction_allowed (ras_allowed),
    .i_link_address       (i_link_address),
    .o_valid              (ras_valid),
    .o_target             (ras_target)
  );

  // ========================================
  // Gating and selection
  // ========================================
  logic        prediction_common;
  logic        btb_predicts;
  logic        sel_btb;
  logic        sel_ras;
  logic        btb_only_used;
  prediction_t prediction_d;

  // Own holdoff blocks the stale word after a redirect
  assign prediction_common = !i_reset && !i_stall && !i_redirect && !i_holdoff &&
                             !i_disable && !o_prediction_holdoff;
  assign ras_allowed       = prediction_common;

  assign btb_predicts = btb_hit && btb_taken;
  assign sel_btb      = prediction_common && btb_predicts;
  assign sel_ras      = prediction_common && ras_valid;

  // Resolved branch in execute overrides any prediction
  assign o_prediction_used  = (sel_ras || sel_btb) && !i_branch_taken;
  assign o_predicted_taken  = sel_ras || btb_predicts;
  // Stack target wins for returns
  assign o_predicted_target = sel_ras ? ras_target : btb_target;
  assign o_ras_predicted    = sel_ras;

  assign btb_only_used = sel_btb && !sel_ras && !i_branch_taken;

  assign prediction_d.used   = o_prediction_used;
  assign prediction_d.target = o_predicted_target;

  // ========================================
  // Registered metadata and holdoffs
  // ========================================
  // Metadata lines up with the instruction arriving one cycle later
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_prediction_r       <= '0;
      o_prediction_holdoff <= 1'b0;
      o_btb_only_holdoff   <= 1'b0;
    end else if (!i_stall) begin
      o_prediction_r       <= prediction_d;
      // Flush drops any pending holdoff
      o_prediction_holdoff <= i_flush ? 1'b0 : o_prediction_used;
      o_btb_only_holdoff   <= i_flush ? 1'b0 : btb_only_used;
    end
  end

endmodule : branch_prediction_controller

// ==== return_address_stack.sv ====
// ========================================
// Circular return address stack
// Pushes link addresses on calls, predicts
// and pops the top entry on returns
// ========================================

`timescale 1ns/100ps

`include "bp_consts.svh"

module return_address_stack (
  input  logic          i_clk,
  input  logic          i_reset,
  input  logic          i_stall,
  input  logic          i_is_call,
  input  logic          i_is_return,
  input  logic          i_prediction_allowed,
  input  bp_pkg::addr_t i_link_address,
  output logic          o_valid,
  output bp_pkg::addr_t o_target
);

  import bp_pkg::*;

  // Count value of a full stack
  localparam logic [`BP_RAS_PTR_BITS:0] full_count = `BP_RAS_DEPTH;

  // ========================================
  // State
  // ========================================
  addr_t                       stack_mem [`BP_RAS_DEPTH];
  logic [`BP_RAS_PTR_BITS-1:0] tos_q;
  logic [`BP_RAS_PTR_BITS:0]   count_q;

  logic [`BP_RAS_PTR_BITS-1:0] tos_inc;
  logic [`BP_RAS_PTR_BITS-1:0] tos_dec;
  logic                        push;
  logic                        pop;

  // Pointer wraps with the stack size
  assign tos_inc = tos_q + 1'b1;
  assign tos_dec = tos_q - 1'b1;

  // ========================================
  // Prediction
  // ========================================
  // Only a decoded return with live entries predicts
  assign o_valid  = i_is_return && (count_q != '0);
  assign o_target = stack_mem[tos_q];

  // Push wins over pop in the same cycle
  assign push = i_is_call && i_prediction_allowed;
  assign pop  = i_prediction_allowed && o_valid && !push;

  // ========================================
  // Pointer and count
  // ========================================
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      tos_q   <= '0;
      count_q <= '0;
    end else if (!i_stall) begin
      if (push) begin
        tos_q <= tos_inc;
        // Full stack keeps its count, oldest entry is lost
        if (count_q != full_count) begin
          count_q <= count_q + 1'b1;
        end
      end else if (pop) begin
        tos_q   <= tos_dec;
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry above the old top takes the link address
  always_ff @(posedge i_clk) begin
    if (!i_stall && push) begin
      stack_mem[tos_inc] <= i_link_address;
    end
  end

endmodule : return_address_stack

// ==== ras_detector.sv ====
// ========================================
// Call and return decoder for the RAS
// Purely combinational on the fetched word
// ========================================

`timescale 1ns/100ps

`include "bp_consts.svh"

module ras_detector (
  input  bp_pkg::instr_u i_instruction,
  input  logic           i_instruction_valid,
  output logic           o_is_call,
  output logic           o_is_return
);

  logic is_jal;
  logic is_jalr;
  logic jal_rd_link;
  logic jalr_rd_link;
  logic jalr_rs1_link;

  // Opcode field is shared by both views
  assign is_jal  = (i_instruction.jal.opcode == `BP_OPC_JAL);
  assign is_jalr = (i_instruction.jalr.opcode == `BP_OPC_JALR) &&
                   (i_instruction.jalr.funct3 == 3'b000);

  // Link registers are x1 (ra) and x5 (t0)
  assign jal_rd_link   = (i_instruction.jal.rd == 5'd1) || (i_instruction.jal.rd == 5'd5);
  assign jalr_rd_link  = (i_instruction.jalr.rd == 5'd1) || (i_instruction.jalr.rd == 5'd5);
  assign jalr_rs1_link = (i_instruction.jalr.rs1 == 5'd1) || (i_instruction.jalr.rs1 == 5'd5);

  // Call writes a link register
  assign o_is_call = i_instruction_valid &&
                     ((is_jal && jal_rd_link) || (is_jalr && jalr_rd_link));

  // Return jumps through a link register and discards the link
  assign o_is_return = i_instruction_valid && is_jalr && jalr_rs1_link &&
                       (i_instruction.jalr.rd == 5'd0) && !o_is_call;

endmodule : ras_detector

// ==== btb.sv ====
// ========================================
// Direct-mapped branch target buffer
// Lookup is combinational on the fetch PC,
// updates from execute land at the clock edge
// ========================================

`timescale 1ns/100ps

`include "bp_consts.svh"

module btb (
  input  logic                i_clk,
  input  logic                i_reset,
  input  bp_pkg::addr_t       i_pc,
  input  bp_pkg::btb_update_t i_update,
  output logic                o_hit,
  output logic                o_taken,
  output bp_pkg::addr_t       o_target
);

  import bp_pkg::*;

  // Index sits just above the word offset, tag takes the rest
  localparam int unsigned idx_lsb  = 2;
  localparam int unsigned tag_lsb  = idx_lsb + `BP_BTB_IDX_BITS;
  localparam int unsigned tag_bits = `BP_XLEN - tag_lsb;

  // ========================================
  // Storage
  // ========================================
  logic [`BP_BTB_ENTRIES-1:0] valid_q;
  logic [tag_bits-1:0]        tag_mem    [`BP_BTB_ENTRIES];
  addr_t                      target_mem [`BP_BTB_ENTRIES];
  logic [`BP_BTB_ENTRIES-1:0] taken_mem;

  // ========================================
  // Lookup
  // ========================================
  logic [`BP_BTB_IDX_BITS-1:0] rd_idx;
  logic [tag_bits-1:0]         rd_tag;

  assign rd_idx = i_pc[tag_lsb-1:idx_lsb];
  assign rd_tag = i_pc[`BP_XLEN-1:tag_lsb];

  // Hit needs a live entry with a matching tag
  assign o_hit    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  // Direction only counts together with a hit
  assign o_taken  = o_hit && taken_mem[rd_idx];
  assign o_target = target_mem[rd_idx];

  // ========================================
  // Update
  // ========================================
  logic [`BP_BTB_IDX_BITS-1:0] wr_idx;

  assign wr_idx = i_update.pc[tag_lsb-1:idx_lsb];

  // Valid bits come up cleared
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      valid_q <= '0;
    end else if (i_update.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Whole entry is replaced on every update
  always_ff @(posedge i_clk) begin
    if (i_update.valid) begin
      tag_mem[wr_idx]    <= i_update.pc[`BP_XLEN-1:tag_lsb];
      target_mem[wr_idx] <= i_update.target;
      taken_mem[wr_idx]  <= i_update.taken;
    end
  end

endmodule : btb

// ==== bp_pkg.sv ====
// ========================================
// Shared types of the branch predictor
// Import into module bodies, use scoped
// names in port lists
// ========================================

`include "bp_consts.svh"

package bp_pkg;

  // Fetch and target address
  typedef logic [`BP_XLEN-1:0] addr_t;

  // J-type layout, immediate bits scrambled as in the ISA
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } jal_fmt_t;

  // I-type layout used by JALR
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } jalr_fmt_t;

  // One instruction word, seen as either jump format
  typedef union packed {
    jal_fmt_t  jal;
    jalr_fmt_t jalr;
  } instr_u;

  // Execute-stage BTB update, 66 bits
  typedef struct packed {
    logic  valid;
    addr_t pc;
    addr_t target;
    logic  taken;
  } btb_update_t;

  // Registered prediction metadata, 33 bits
  typedef struct packed {
    logic  used;
    addr_t target;
  } prediction_t;

endpackage : bp_pkg

// ==== bp_consts.svh ====
// ========================================
// Widths, table sizes and opcode constants
// for the fetch-stage branch predictor
// Include wherever a size or opcode is needed
// ========================================

`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Address and data width
`define BP_XLEN 32

// Branch target buffer geometry
`define BP_BTB_ENTRIES 16
`define BP_BTB_IDX_BITS 4

// Return address stack geometry
`define BP_RAS_DEPTH 8
`define BP_RAS_PTR_BITS 3

// RV32I jump opcodes
`define BP_OPC_JAL 7'b1101111
`define BP_OPC_JALR 7'b1100111

`endif
